// ==== Makefile ====
TOP := neuralClassifierTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Verification passed" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== dv/neuralClassifierAssertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module neuralClassifierAssertions
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire sampleValid,
	input wire activation_t classScore,
	input wire resultValid
);

	localparam int PIPE_LATENCY = 8;
	localparam logic [3:0] LAST_COUNT = 4'(`NN_INPUTS - 1);

	logic [3:0] strobeCount;
	logic lastStrobe;

	always_ff @(posedge clk)
	begin
		if (reset)
			strobeCount <= '0;
		else if (sampleValid)
			strobeCount <= (strobeCount == LAST_COUNT) ? '0 : strobeCount + 4'd1;
	end

	assign lastStrobe = sampleValid && (strobeCount == LAST_COUNT);

	// Loader, two layers of three stages each, then the argmax register.
	resultLatency: assert property (@(posedge clk) disable iff (reset)
		lastStrobe |-> ##PIPE_LATENCY resultValid)
		else $error("No result %0d cycles after the fifteenth sample.", PIPE_LATENCY);

	resultOrigin: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(lastStrobe, PIPE_LATENCY))
		else $error("Result without a fifteenth sample %0d cycles before.", PIPE_LATENCY);

	quietInReset: assert property (@(posedge clk) reset |=> !resultValid)
		else $error("Result while reset is held.");

	quietAfterReset: assert property (@(posedge clk) $fell(reset) |=> !resultValid)
		else $error("Result in the cycle after reset.");

	// Sign bit clear means the score is within 0 to 127.
	scoreRange: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> !classScore[`NN_ACT_WIDTH-1])
		else $error("Score out of range.");

endmodule

bind neuralClassifier neuralClassifierAssertions resultChecks (
	.clk(clk),
	.reset(reset),
	.sampleValid(sampleValid),
	.classScore(classScore),
	.resultValid(resultValid)
);

`default_nettype wire

// ==== dv/neuralClassifierTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module neuralClassifierTb
	import nnPkg::*;
();

	localparam int NUM_FRAMES = 6 + 16 + 4 + 2;
	localparam int GAP_CYCLES = 12;
	localparam int CYCLE_LIMIT = NUM_FRAMES * (`NN_INPUTS + GAP_CYCLES) + 8 + 200;
	localparam int SEARCH_TRIES = 20000;
	// Neuron sums from 8160 round up to the cap and from 8192 saturate.
	localparam int CAP_SUM = 8160;
	localparam int SAT_SUM = 8192;

	logic clk;
	logic reset;
	logic sampleValid;
	activation_t sampleData;
	logic [1:0] classId;
	activation_t classScore;
	logic resultValid;

	logic [31:0] lcgState;
	int cycleCount;
	int resultCount;
	int frameCount;
	logic [1:0] expIds[$];
	activation_t expScores[$];
	activation_t frame[`NN_INPUTS];

	neuralClassifier uut (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.classId(classId),
		.classScore(classScore),
		.resultValid(resultValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	function automatic activation_t nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return activation_t'(lcgState[31:24]);
	endfunction

	// Rectify, round half up at bit 5, then clamp to 127.
	function automatic activation_t activate(input int sum);
		int q;
		if (sum < 0)
			return '0;
		q = (sum + 32) >>> 6;
		if (q > 127)
			q = 127;
		return activation_t'(q);
	endfunction

	function automatic int hiddenSum(input int n);
		int sum;
		sum = int'(HIDDEN_BIAS[n]);
		for (int i = 0; i < `NN_INPUTS; i++)
			sum += int'(frame[i]) * int'(HIDDEN_WEIGHTS[n][i]);
		return sum;
	endfunction

	function automatic logic inWindow(input int sum, input int lo, input int hi,
		input logic needHalf);
		return sum >= lo && sum <= hi && (!needHalf || sum[5]);
	endfunction

	task automatic modelFrame(output logic [1:0] bestId, output activation_t bestScore,
		output int bestSum);
		activation_t hidden[`NN_HIDDEN];
		activation_t score;
		int sum;
		for (int n = 0; n < `NN_HIDDEN; n++)
			hidden[n] = activate(hiddenSum(n));
		for (int k = 0; k < `NN_OUTPUTS; k++)
		begin
			sum = int'(OUTPUT_BIAS[k]);
			for (int n = 0; n < `NN_HIDDEN; n++)
				sum += int'(hidden[n]) * int'(OUTPUT_WEIGHTS[k][n]);
			score = activate(sum);
			// A tie keeps the lower class.
			if (k == 0 || score > bestScore)
			begin
				bestId = 2'(k);
				bestScore = score;
				bestSum = sum;
			end
		end
	endtask

	task automatic fillFrame(input int value);
		for (int i = 0; i < `NN_INPUTS; i++)
			frame[i] = activation_t'(value);
	endtask

	task automatic randomFrame(input int shift);
		for (int i = 0; i < `NN_INPUTS; i++)
			frame[i] = nextRandom() >>> shift;
	endtask

	// Looks at any hidden neuron sum, or else at the winning output sum.
	task automatic findFrame(input int lo, input int hi, input logic needHalf,
		input logic inHidden);
		logic [1:0] id;
		activation_t score;
		int sum;
		logic found;
		for (int tries = 0; tries < SEARCH_TRIES; tries++)
		begin
			randomFrame(tries % 4);
			modelFrame(id, score, sum);
			found = inHidden ? 1'b0 : inWindow(sum, lo, hi, needHalf);
			for (int n = 0; n < `NN_HIDDEN; n++)
				if (inHidden && inWindow(hiddenSum(n), lo, hi, needHalf))
					found = 1'b1;
			if (found)
				return;
		end
		abortRun($sformatf("No frame found with a neuron sum from %0d to %0d.", lo, hi));
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(negedge clk);
			sampleValid = 1'b0;
			sampleData = '0;
		end
	endtask

	task automatic sendFrame(input int gap);
		logic [1:0] id;
		activation_t score;
		int sum;
		modelFrame(id, score, sum);
		expIds.push_back(id);
		expScores.push_back(score);
		frameCount++;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			@(negedge clk);
			sampleValid = 1'b1;
			sampleData = frame[i];
		end
		if (gap > 0)
			idleCycles(gap);
	endtask

	task automatic drainResults();
		idleCycles(1);
		while (expIds.size() != 0)
			@(negedge clk);
	endtask

	always @(negedge clk)
	begin
		if (!reset && resultValid)
		begin
			assert (expIds.size() != 0)
			else abortRun("A result came out with no frame pending.");
			assert (classId == expIds[0] && classScore == expScores[0])
			else abortRun($sformatf(
				"mismatch at %0t: result %0d class %0d score %0d, expected %0d score %0d",
				$time, resultCount, classId, classScore, expIds[0], expScores[0]));
			void'(expIds.pop_front());
			void'(expScores.pop_front());
			resultCount++;
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT)
			abortRun($sformatf("Timeout after %0d cycles with %0d results still pending.",
				cycleCount, expIds.size()));
	end

	initial
	begin
		reset = 1'b1;
		sampleValid = 1'b0;
		sampleData = '0;
		lcgState = 32'h6034d626;
		cycleCount = 0;
		resultCount = 0;
		frameCount = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		fillFrame(0);
		sendFrame(2);
		fillFrame(-128);
		sendFrame(2);
		fillFrame(127);
		sendFrame(2);
		// Output sums stay below the cap, so saturation and the cap show in the hidden layer.
		findFrame(SAT_SUM, 1 << 22, 1'b0, 1'b1);
		sendFrame(2);
		findFrame(0, CAP_SUM - 1, 1'b1, 1'b0);
		sendFrame(2);
		findFrame(CAP_SUM, SAT_SUM - 1, 1'b1, 1'b1);
		sendFrame(2);

		for (int f = 0; f < 16; f++)
		begin
			randomFrame(f % 3);
			sendFrame(1 + f % 4);
		end
		// Back to back with no idle cycle between frames.
		for (int f = 0; f < 4; f++)
		begin
			randomFrame(1);
			sendFrame(0);
		end
		drainResults();

		// Reset hits four samples into a frame while the previous result is in flight.
		randomFrame(0);
		sendFrame(0);
		randomFrame(0);
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			sampleValid = 1'b1;
			sampleData = frame[i];
		end
		@(negedge clk);
		reset = 1'b1;
		// The reset drops the result of the frame in flight.
		void'(expIds.pop_back());
		void'(expScores.pop_back());
		frameCount--;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		sampleValid = 1'b0;
		randomFrame(0);
		sendFrame(1);
		drainResults();
		idleCycles(GAP_CYCLES);

		if (resultCount == frameCount && expIds.size() == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			abortRun($sformatf("Expected %0d results but saw %0d.", frameCount, resultCount));
		end
	end

endmodule

`default_nettype wire

// ==== hdl/classSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module classSelect
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire activation_t [`NN_OUTPUTS-1:0] scoreData,
	input wire scoreValid,
	output logic [1:0] classId,
	output activation_t classScore,
	output logic resultValid
);

	logic [1:0] bestId;
	activation_t bestScore;

	// Strict compare, so the lowest index keeps a tie.
	always_comb
	begin
		bestId = '0;
		bestScore = scoreData[0];
		for (int i = 1; i < `NN_OUTPUTS; i++)
		begin
			if (scoreData[i] > bestScore)
			begin
				bestId = 2'(i);
				bestScore = scoreData[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classId <= '0;
			classScore <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= scoreValid;
			if (scoreValid)
			begin
				classId <= bestId;
				classScore <= bestScore;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/denseLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module denseLayer
	import nnPkg::*;
#(
	parameter int NUM_INPUTS = `NN_INPUTS,
	parameter int NUM_NEURONS = `NN_HIDDEN,
	parameter weight_t [NUM_NEURONS-1:0][NUM_INPUTS-1:0] WEIGHTS = '0,
	parameter bias_t [NUM_NEURONS-1:0] BIAS = '0
)
(
	input wire clk,
	input wire reset,
	input wire activation_t [NUM_INPUTS-1:0] inData,
	input wire inValid,
	output activation_t [NUM_NEURONS-1:0] outData,
	output logic outValid
);

	// Input, sum and output registers inside each node.
	localparam int NODE_LATENCY = 3;

	logic [NODE_LATENCY-1:0] validPipe;

	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : neuronGen
		neuronNode #(
			.NUM_INPUTS(NUM_INPUTS),
			.WEIGHTS(WEIGHTS[n]),
			.BIAS(BIAS[n])
		) node (
			.clk(clk),
			.reset(reset),
			.inData(inData),
			.outData(outData[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[NODE_LATENCY-2:0], inValid};
	end

	assign outValid = validPipe[NODE_LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/featureLoader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module featureLoader
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire sampleValid,
	input wire activation_t sampleData,
	output activation_t [`NN_INPUTS-1:0] frameData,
	output logic frameValid
);

	localparam int COUNT_WIDTH = $clog2(`NN_INPUTS);
	localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(`NN_INPUTS - 1);

	activation_t [`NN_INPUTS-1:0] shiftReg;
	activation_t [`NN_INPUTS-1:0] shiftNext;
	logic [COUNT_WIDTH-1:0] count;

	// New samples enter at the top, so the first sample of a frame ends up at index 0.
	assign shiftNext = {sampleData, shiftReg[`NN_INPUTS-1:1]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			shiftReg <= '0;
			frameData <= '0;
			frameValid <= 1'b0;
			count <= '0;
		end
		else
		begin
			frameValid <= 1'b0;
			if (sampleValid)
			begin
				shiftReg <= shiftNext;
				if (count == LAST_COUNT)
				begin
					// Publish the whole frame, held until the next one completes.
					frameData <= shiftNext;
					frameValid <= 1'b1;
					count <= '0;
				end
				else
				begin
					count <= count + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/neuralClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module neuralClassifier
	import nnPkg::*;
(
	input wire clk,
	input wire reset,
	input wire sampleValid,
	input wire activation_t sampleData,
	output logic [1:0] classId,
	output activation_t classScore,
	output logic resultValid
);

	activation_t [`NN_INPUTS-1:0] frameData;
	logic frameValid;
	activation_t [`NN_HIDDEN-1:0] hiddenData;
	logic hiddenValid;
	activation_t [`NN_OUTPUTS-1:0] scoreData;
	logic scoreValid;

	featureLoader loader (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.frameData(frameData),
		.frameValid(frameValid)
	);

	denseLayer #(
		.NUM_INPUTS(`NN_INPUTS),
		.NUM_NEURONS(`NN_HIDDEN),
		.WEIGHTS(HIDDEN_WEIGHTS),
		.BIAS(HIDDEN_BIAS)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inData(frameData),
		.inValid(frameValid),
		.outData(hiddenData),
		.outValid(hiddenValid)
	);

	denseLayer #(
		.NUM_INPUTS(`NN_HIDDEN),
		.NUM_NEURONS(`NN_OUTPUTS),
		.WEIGHTS(OUTPUT_WEIGHTS),
		.BIAS(OUTPUT_BIAS)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inData(hiddenData),
		.inValid(hiddenValid),
		.outData(scoreData),
		.outValid(scoreValid)
	);

	classSelect selector (
		.clk(clk),
		.reset(reset),
		.scoreData(scoreData),
		.scoreValid(scoreValid),
		.classId(classId),
		.classScore(classScore),
		.resultValid(resultValid)
	);

endmodule

`default_nettype wire

// ==== hdl/neuronNode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nn_defines.svh"

module neuronNode
	import nnPkg::*;
#(
	parameter int NUM_INPUTS = `NN_INPUTS,
	parameter weight_t [NUM_INPUTS-1:0] WEIGHTS = '0,
	parameter bias_t BIAS = '0
)
(
	input wire clk,
	input wire reset,
	input wire activation_t [NUM_INPUTS-1:0] inData,
	output activation_t outData
);

	localparam int PROD_WIDTH = 2 * `NN_ACT_WIDTH;
	// Output window of the sum: bits 13 down to 6, rounding bit 5.
	localparam int WIN_LSB = `NN_FRAC_BITS;
	localparam int WIN_MSB = WIN_LSB + `NN_ACT_WIDTH - 1;
	localparam activation_t ACT_MAX = activation_t'((1 << (`NN_ACT_WIDTH - 1)) - 1);

	activation_t [NUM_INPUTS-1:0] inReg;
	logic signed [PROD_WIDTH-1:0] products [NUM_INPUTS];
	accumulator_t sumNext;
	accumulator_t sumReg;
	logic [`NN_ACT_WIDTH-1:0] rounded;

	for (genvar i = 0; i < NUM_INPUTS; i++)
	begin : productGen
		assign products[i] = PROD_WIDTH'(inReg[i]) * PROD_WIDTH'(WEIGHTS[i]);
	end

	always_comb
	begin
		sumNext = accumulator_t'(BIAS);
		for (int i = 0; i < NUM_INPUTS; i++)
			sumNext = sumNext + accumulator_t'(products[i]);
	end

	// Round half up; only reaches 128 when the window is 127 and bit 5 is set.
	assign rounded = sumReg[WIN_MSB:WIN_LSB] + `NN_ACT_WIDTH'(sumReg[WIN_LSB-1]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			outData <= '0;
		end
		else
		begin
			inReg <= inData;
			sumReg <= sumNext;
			if (sumReg[`NN_ACC_WIDTH-1])
				outData <= '0;
			else if (|sumReg[`NN_ACC_WIDTH-2:WIN_MSB])
				outData <= ACT_MAX;
			else if (rounded[`NN_ACT_WIDTH-1])
				outData <= ACT_MAX;
			else
				outData <= activation_t'(rounded);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/nnPkg.sv ====
`default_nettype none

`include "nn_defines.svh"

package nnPkg;

	typedef logic signed [`NN_ACT_WIDTH-1:0] activation_t;
	typedef logic signed [`NN_ACT_WIDTH-1:0] weight_t;
	typedef logic signed [2*`NN_ACT_WIDTH-1:0] bias_t;
	typedef logic signed [`NN_ACC_WIDTH-1:0] accumulator_t;

	// Rows are listed from the highest index down, so element [n][i] is neuron n, input i.
	localparam weight_t [`NN_HIDDEN-1:0][`NN_INPUTS-1:0] HIDDEN_WEIGHTS = '{
		'{-8'sd14, 8'sd4, -8'sd16, 8'sd22, -8'sd2, 8'sd15, -8'sd10, 8'sd7,
			8'sd18, -8'sd28, 8'sd6, 8'sd20, 8'sd13, -8'sd19, -8'sd5},
		'{8'sd11, -8'sd24, -8'sd5, 8'sd16, 8'sd30, 8'sd2, -8'sd13, -8'sd21,
			8'sd8, 8'sd12, 8'sd27, -8'sd6, -8'sd17, 8'sd4, 8'sd9},
		'{8'sd6, -8'sd9, 8'sd21, -8'sd15, -8'sd4, 8'sd19, 8'sd3, 8'sd11,
			-8'sd26, 8'sd14, -8'sd8, 8'sd23, 8'sd5, 8'sd17, -8'sd12},
		'{8'sd24, 8'sd9, -8'sd11, -8'sd18, -8'sd7, -8'sd18, 8'sd25, -8'sd3,
			-8'sd14, -8'sd7, -8'sd19, -8'sd11, 8'sd31, -8'sd22, 8'sd28}
	};

	// Biases carry 12 fraction bits, so 1024 is 0.25.
	localparam bias_t [`NN_HIDDEN-1:0] HIDDEN_BIAS = '{
		16'sd768,
		16'sd256,
		-16'sd512,
		16'sd1024
	};

	localparam weight_t [`NN_OUTPUTS-1:0][`NN_HIDDEN-1:0] OUTPUT_WEIGHTS = '{
		'{8'sd33, -8'sd38, 8'sd10, 8'sd15},
		'{8'sd22, -8'sd15, 8'sd35, -8'sd20},
		'{-8'sd30, 8'sd18, -8'sd25, 8'sd40}
	};

	localparam bias_t [`NN_OUTPUTS-1:0] OUTPUT_BIAS = '{
		-16'sd256,
		16'sd256,
		16'sd512
	};

endpackage

`default_nettype wire

// ==== hdl/nn_defines.svh ====
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

// Layer sizes.
`define NN_INPUTS 15
`define NN_HIDDEN 4
`define NN_OUTPUTS 3

// Activations and weights are 8-bit signed, 6 fraction bits on activations.
`define NN_ACT_WIDTH 8
`define NN_FRAC_BITS 6

// Sum of fifteen 16-bit products and a bias, with headroom.
`define NN_ACC_WIDTH 23

`endif

// ==== sim.f ====
+incdir+hdl
hdl/nnPkg.sv
hdl/featureLoader.sv
hdl/neuronNode.sv
hdl/denseLayer.sv
hdl/classSelect.sv
hdl/neuralClassifier.sv
dv/neuralClassifierAssertions.sv
dv/neuralClassifierTb.sv
